// ==== tilevid_pkg.sv ====
// Shared constants for the tile-video subsystem.
// CPU window layout, scroll register offsets, tile map shape and widths.
`default_nettype none

package tilevid_pkg;

    // ******************************
    // CPU window
    // ******************************
    localparam int addr_w = 11;
    localparam int data_w = 16;
    localparam int be_w   = 2;
    localparam int off_w  = 8;

    // Words below this address are tile RAM, the rest are registers.
    localparam logic [addr_w-1:0] reg_base = 11'h700;

    // Word offsets inside the register window.
    localparam logic [off_w-1:0] off_pages1_std = 8'h40;
    localparam logic [off_w-1:0] off_pages2_std = 8'h41;
    localparam logic [off_w-1:0] off_pages1_alt = 8'h42;
    localparam logic [off_w-1:0] off_pages2_alt = 8'h43;
    localparam logic [off_w-1:0] off_vpos1_std  = 8'h48;
    localparam logic [off_w-1:0] off_vpos2_std  = 8'h49;
    localparam logic [off_w-1:0] off_vpos1_alt  = 8'h4A;
    localparam logic [off_w-1:0] off_vpos2_alt  = 8'h4B;
    localparam logic [off_w-1:0] off_hpos1_std  = 8'h4C;
    localparam logic [off_w-1:0] off_hpos2_std  = 8'h4D;
    localparam logic [off_w-1:0] off_hpos1_alt  = 8'h4E;
    localparam logic [off_w-1:0] off_hpos2_alt  = 8'h4F;

    // ******************************
    // Tile map
    // ******************************
    localparam int tile_px    = 8;
    localparam int map_cols   = 16;
    localparam int map_rows   = 16;
    localparam int page_words = 256;
    localparam int pos_w      = 9;
    localparam int page_w     = 3;

    // This page maps onto the register window, so it reads as blank.
    localparam logic [page_w-1:0] page_none = 3'd7;

    // Status dump.
    localparam int st_entries = 12;
    localparam int st_w       = 8;

endpackage

`default_nettype wire

// ==== char_window.sv ====
// CPU character window.
// Tile RAM with byte-lane writes, register write decode and RAM port arbitration.
`default_nettype none

module char_window import tilevid_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // CPU write port
    input  logic              cpu_valid,
    output logic              cpu_ready,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_data,
    input  logic [be_w-1:0]   cpu_be,
    // Register strobe
    output logic              reg_we,
    output logic [off_w-1:0]  reg_off,
    output logic [data_w-1:0] reg_data,
    output logic [be_w-1:0]   reg_be,
    // Fetch read port
    input  logic              ram_rd,
    input  logic [addr_w-1:0] ram_addr,
    output logic [data_w-1:0] ram_q
);

    logic [data_w-1:0] tile_ram [0:reg_base-1];
    logic              cpu_accept;
    logic              in_regs;
    logic              ram_we;

    // Video reads own the RAM port, the CPU waits.
    assign cpu_ready  = !ram_rd;
    assign cpu_accept = cpu_valid && cpu_ready;
    assign in_regs    = cpu_addr >= reg_base;

    // ******************************
    // Register window
    // ******************************
    assign reg_we   = cpu_accept && in_regs;
    assign reg_off  = cpu_addr[off_w-1:0];
    assign reg_data = cpu_data;
    assign reg_be   = cpu_be;

    // ******************************
    // Tile RAM
    // ******************************
    // Writes seen while in reset are dropped.
    assign ram_we = cpu_accept && !in_regs && !reset;

    always_ff @(posedge clk) begin
        if (ram_rd) begin
            ram_q <= tile_ram[ram_addr];
        end else if (ram_we) begin
            if (cpu_be[0]) begin
                tile_ram[cpu_addr][7:0] <= cpu_data[7:0];
            end
            if (cpu_be[1]) begin
                tile_ram[cpu_addr][15:8] <= cpu_data[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== scroll_mmr.sv ====
// Scroll registers for two tile layers.
// Standard and alternate banks, byte-lane writes, per-layer bank select,
// row-scroll enables and a byte-wide status dump.
`default_nettype none

module scroll_mmr import tilevid_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // Register write strobe
    input  logic              reg_we,
    input  logic [off_w-1:0]  reg_off,
    input  logic [data_w-1:0] reg_data,
    input  logic [be_w-1:0]   reg_be,
    // Bank select per layer
    input  logic              altscr1_en,
    input  logic              altscr2_en,
    // Selected values
    output logic [data_w-1:0] pages1,
    output logic [data_w-1:0] pages2,
    output logic [data_w-1:0] hpos1,
    output logic [data_w-1:0] hpos2,
    output logic [data_w-1:0] vpos1,
    output logic [data_w-1:0] vpos2,
    output logic              rowscr1_en,
    output logic              rowscr2_en,
    // Status dump
    input  logic [st_w-1:0]   st_addr,
    output logic [st_w-1:0]   st_dout
);

    logic [data_w-1:0] pages1_std, pages2_std, pages1_alt, pages2_alt;
    logic [data_w-1:0] vpos1_std, vpos2_std, vpos1_alt, vpos2_alt;
    logic [data_w-1:0] hpos1_std, hpos2_std, hpos1_alt, hpos2_alt;
    logic [st_entries*st_w-1:0] dump_bytes;

    // Replace only the enabled bytes of a register.
    function automatic logic [data_w-1:0] lane_merge(
        input logic [data_w-1:0] old_val,
        input logic [data_w-1:0] new_val,
        input logic [be_w-1:0]   be
    );
        return {be[1] ? new_val[15:8] : old_val[15:8],
                be[0] ? new_val[7:0]  : old_val[7:0]};
    endfunction

    // ******************************
    // Bank registers
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pages1_std <= '0;
            pages2_std <= '0;
            pages1_alt <= '0;
            pages2_alt <= '0;
            vpos1_std  <= '0;
            vpos2_std  <= '0;
            vpos1_alt  <= '0;
            vpos2_alt  <= '0;
            hpos1_std  <= '0;
            hpos2_std  <= '0;
            hpos1_alt  <= '0;
            hpos2_alt  <= '0;
        end else if (reg_we) begin
            case (reg_off)
                off_pages1_std: pages1_std <= lane_merge(pages1_std, reg_data, reg_be);
                off_pages2_std: pages2_std <= lane_merge(pages2_std, reg_data, reg_be);
                off_pages1_alt: pages1_alt <= lane_merge(pages1_alt, reg_data, reg_be);
                off_pages2_alt: pages2_alt <= lane_merge(pages2_alt, reg_data, reg_be);
                off_vpos1_std:  vpos1_std  <= lane_merge(vpos1_std, reg_data, reg_be);
                off_vpos2_std:  vpos2_std  <= lane_merge(vpos2_std, reg_data, reg_be);
                off_vpos1_alt:  vpos1_alt  <= lane_merge(vpos1_alt, reg_data, reg_be);
                off_vpos2_alt:  vpos2_alt  <= lane_merge(vpos2_alt, reg_data, reg_be);
                off_hpos1_std:  hpos1_std  <= lane_merge(hpos1_std, reg_data, reg_be);
                off_hpos2_std:  hpos2_std  <= lane_merge(hpos2_std, reg_data, reg_be);
                off_hpos1_alt:  hpos1_alt  <= lane_merge(hpos1_alt, reg_data, reg_be);
                off_hpos2_alt:  hpos2_alt  <= lane_merge(hpos2_alt, reg_data, reg_be);
                default: ;
            endcase
        end
    end

    // ******************************
    // Bank select
    // ******************************
    // Each layer picks its bank on its own enable.
    always_ff @(posedge clk) begin
        if (reset) begin
            pages1 <= '0;
            pages2 <= '0;
            vpos1  <= '0;
            vpos2  <= '0;
            hpos1  <= '0;
            hpos2  <= '0;
        end else begin
            pages1 <= altscr1_en ? pages1_alt : pages1_std;
            vpos1  <= altscr1_en ? vpos1_alt  : vpos1_std;
            hpos1  <= altscr1_en ? hpos1_alt  : hpos1_std;
            pages2 <= altscr2_en ? pages2_alt : pages2_std;
            vpos2  <= altscr2_en ? vpos2_alt  : vpos2_std;
            hpos2  <= altscr2_en ? hpos2_alt  : hpos2_std;
        end
    end

    // Row scroll is flagged by the top bit of horizontal scroll.
    assign rowscr1_en = hpos1[15];
    assign rowscr2_en = hpos2[15];

    // ******************************
    // Status dump
    // ******************************
    // Byte 0 is the low byte of pages1, byte 11 the high byte of hpos2.
    assign dump_bytes = {hpos2, hpos1, vpos2, vpos1, pages2, pages1};

    always_ff @(posedge clk) begin
        if (reset) begin
            st_dout <= '0;
        end else if (st_addr < st_entries) begin
            st_dout <= dump_bytes[st_w*st_addr +: st_w];
        end else begin
            st_dout <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== tile_fetch.sv ====
// Tile fetcher.
// Screen position plus layer scroll to tile map address, RAM read,
// and a two-entry output holding stage.
`default_nettype none

module tile_fetch import tilevid_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // Tile request
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_layer,
    input  logic [pos_w-1:0]  req_h,
    input  logic [pos_w-1:0]  req_v,
    // Tile response
    output logic              tile_valid,
    input  logic              tile_ready,
    output logic [data_w-1:0] tile_data,
    // RAM read port
    output logic              ram_rd,
    output logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_q,
    // Scroll values
    input  logic [data_w-1:0] pages1,
    input  logic [data_w-1:0] pages2,
    input  logic [data_w-1:0] hpos1,
    input  logic [data_w-1:0] hpos2,
    input  logic [data_w-1:0] vpos1,
    input  logic [data_w-1:0] vpos2
);

    localparam int tile_sh = $clog2(tile_px);
    localparam int col_w   = $clog2(map_cols);
    localparam int row_w   = $clog2(map_rows);

    logic [data_w-1:0] layer_hpos, layer_vpos;
    logic [page_w-1:0] layer_page;
    logic [pos_w-1:0]  pos_x, pos_y;
    logic [col_w-1:0]  col;
    logic [row_w-1:0]  row;
    logic [addr_w-1:0] map_addr;
    logic              req_fire, tile_fire;
    logic [1:0]        in_flight;
    // Address stage.
    logic              a_valid, a_blank;
    logic [addr_w-1:0] a_addr;
    // Read stage, ram_q is valid while r_valid is high.
    logic              r_valid, r_blank;
    logic [data_w-1:0] r_word;
    // Output holding stage.
    logic [data_w-1:0] hold_mem [2];
    logic [1:0]        hold_count;
    logic              hold_wr_ptr, hold_rd_ptr;

    // ******************************
    // Address computation
    // ******************************
    // Map wraps at 128 pixels, so only the low position bits matter.
    always_comb begin
        layer_hpos = req_layer ? hpos2 : hpos1;
        layer_vpos = req_layer ? vpos2 : vpos1;
        layer_page = req_layer ? pages2[8 +: page_w] : pages1[page_w-1:0];
        pos_x      = req_h + layer_hpos[pos_w-1:0];
        pos_y      = req_v + layer_vpos[pos_w-1:0];
        col        = pos_x[tile_sh +: col_w];
        row        = pos_y[tile_sh +: row_w];
        map_addr   = addr_w'(layer_page) * addr_w'(page_words)
                   + addr_w'(row) * addr_w'(map_cols) + addr_w'(col);
    end

    // Two requests at most between acceptance and delivery.
    assign in_flight = 2'(a_valid) + 2'(r_valid) + hold_count;
    assign tile_fire = tile_valid && tile_ready;
    assign req_ready = (in_flight < 2'd2) || tile_fire;
    assign req_fire  = req_valid && req_ready;

    // Blank page skips the read.
    assign ram_rd   = a_valid && !a_blank;
    assign ram_addr = a_addr;
    assign r_word   = r_blank ? '0 : ram_q;

    assign tile_valid = hold_count != 2'd0;
    assign tile_data  = hold_mem[hold_rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            a_valid     <= 1'b0;
            r_valid     <= 1'b0;
            hold_count  <= '0;
            hold_wr_ptr <= 1'b0;
            hold_rd_ptr <= 1'b0;
        end else begin
            a_valid    <= req_fire;
            r_valid    <= a_valid;
            hold_count <= hold_count + 2'(r_valid) - 2'(tile_fire);
            if (r_valid) begin
                hold_wr_ptr <= !hold_wr_ptr;
            end
            if (tile_fire) begin
                hold_rd_ptr <= !hold_rd_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            a_addr  <= map_addr;
            a_blank <= layer_page == page_none;
        end
        r_blank <= a_blank;
        if (r_valid) begin
            hold_mem[hold_wr_ptr] <= r_word;
        end
    end

endmodule

`default_nettype wire

// ==== tilevid_top.sv ====
// Tile-video subsystem top level.
// Character window, scroll registers and tile fetcher.
`default_nettype none

module tilevid_top import tilevid_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // CPU write port
    input  logic              cpu_valid,
    output logic              cpu_ready,
    input  logic [addr_w-1:0] cpu_addr,
    input  logic [data_w-1:0] cpu_data,
    input  logic [be_w-1:0]   cpu_be,
    // Tile request and response
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_layer,
    input  logic [pos_w-1:0]  req_h,
    input  logic [pos_w-1:0]  req_v,
    output logic              tile_valid,
    input  logic              tile_ready,
    output logic [data_w-1:0] tile_data,
    // Scroll control and status
    input  logic              altscr1_en,
    input  logic              altscr2_en,
    output logic              rowscr1_en,
    output logic              rowscr2_en,
    input  logic [st_w-1:0]   st_addr,
    output logic [st_w-1:0]   st_dout
);

    logic              reg_we;
    logic [off_w-1:0]  reg_off;
    logic [data_w-1:0] reg_data;
    logic [be_w-1:0]   reg_be;
    logic              ram_rd;
    logic [addr_w-1:0] ram_addr;
    logic [data_w-1:0] ram_q;
    logic [data_w-1:0] pages1, pages2, hpos1, hpos2, vpos1, vpos2;

    char_window window_i (
        .clk, .reset,
        .cpu_valid, .cpu_ready, .cpu_addr, .cpu_data, .cpu_be,
        .reg_we, .reg_off, .reg_data, .reg_be,
        .ram_rd, .ram_addr, .ram_q
    );

    scroll_mmr mmr_i (
        .clk, .reset,
        .reg_we, .reg_off, .reg_data, .reg_be,
        .altscr1_en, .altscr2_en,
        .pages1, .pages2, .hpos1, .hpos2, .vpos1, .vpos2,
        .rowscr1_en, .rowscr2_en,
        .st_addr, .st_dout
    );

    tile_fetch fetch_i (
        .clk, .reset,
        .req_valid, .req_ready, .req_layer, .req_h, .req_v,
        .tile_valid, .tile_ready, .tile_data,
        .ram_rd, .ram_addr, .ram_q,
        .pages1, .pages2, .hpos1, .hpos2, .vpos1, .vpos2
    );

endmodule

`default_nettype wire

// ==== tilevid_properties.sv ====
// Concurrent assertions for the tile-video top level.
// RAM port priority, response stability, register strobe width and reset state.
`default_nettype none

module tilevid_properties import tilevid_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              cpu_ready,
    input logic              ram_rd,
    input logic              reg_we,
    input logic              req_ready,
    input logic              tile_valid,
    input logic              tile_ready,
    input logic [data_w-1:0] tile_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // Raised by any failing property below.
    bit assert_failed = 1'b0;

    // ******************************
    // Bus protocol
    // ******************************
    // A fetch read owns the RAM port.
    ram_rd_blocks_cpu: assert property (@(posedge clk) disable iff (reset)
        ram_rd |-> !cpu_ready)
    else begin
        $error("cpu_ready high during a tile RAM read");
        assert_failed = 1'b1;
    end

    // Stalled response must not move.
    tile_holds: assert property (@(posedge clk) disable iff (reset)
        tile_valid && !tile_ready |=> tile_valid && $stable(tile_data))
    else begin
        $error("tile response changed while stalled");
        assert_failed = 1'b1;
    end

    reg_we_single: assert property (@(posedge clk) disable iff (reset)
        reg_we |=> !reg_we)
    else begin
        $error("register strobe longer than one cycle");
        assert_failed = 1'b1;
    end

    // ******************************
    // Reset state
    // ******************************
    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> cpu_ready && req_ready && !tile_valid)
    else begin
        $error("handshake outputs wrong right after reset");
        assert_failed = 1'b1;
    end

endmodule

bind tilevid_top tilevid_properties props_i (
    .clk(clk), .reset(reset), .cpu_ready(cpu_ready), .ram_rd(ram_rd),
    .reg_we(reg_we), .req_ready(req_ready), .tile_valid(tile_valid),
    .tile_ready(tile_ready), .tile_data(tile_data)
);

`default_nettype wire

// ==== tb_tilevid.sv ====
// Testbench for the tile-video top level.
// Reference model of tile RAM and scroll banks, status dump and fetch checks.
`default_nettype none

module tb_tilevid import tilevid_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // Whole run needs roughly 6k cycles.
    localparam int max_cycles = 20000;
    localparam int ram_words  = int'(reg_base);

    logic              clk, reset;
    logic              cpu_valid, cpu_ready;
    logic [addr_w-1:0] cpu_addr;
    logic [data_w-1:0] cpu_data;
    logic [be_w-1:0]   cpu_be;
    logic              req_valid, req_ready, req_layer;
    logic [pos_w-1:0]  req_h, req_v;
    logic              tile_valid, tile_ready;
    logic [data_w-1:0] tile_data;
    logic              altscr1_en, altscr2_en, rowscr1_en, rowscr2_en;
    logic [st_w-1:0]   st_addr, st_dout;

    // Reference state, registers ordered as in the status dump.
    logic [data_w-1:0] ram_model [ram_words];
    logic [data_w-1:0] bank_model [6][2];
    logic [data_w-1:0] exp_q [$];
    int                cycles;
    int                cpu_stalls;

    tilevid_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (dut_i.props_i.assert_failed) begin
            $display("A bound protocol assertion failed");
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end
    end

    task automatic value_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "value check failed");
    endtask

    function automatic logic [off_w-1:0] reg_offset(input int r, input int bank);
        case (r)
            0:       return bank != 0 ? off_pages1_alt : off_pages1_std;
            1:       return bank != 0 ? off_pages2_alt : off_pages2_std;
            2:       return bank != 0 ? off_vpos1_alt : off_vpos1_std;
            3:       return bank != 0 ? off_vpos2_alt : off_vpos2_std;
            4:       return bank != 0 ? off_hpos1_alt : off_hpos1_std;
            default: return bank != 0 ? off_hpos2_alt : off_hpos2_std;
        endcase
    endfunction

    // Value a layer currently sees, even indices are layer 0.
    function automatic logic [data_w-1:0] sel_value(input int r);
        logic alt;
        alt = (r % 2 == 0) ? altscr1_en : altscr2_en;
        return bank_model[r][alt];
    endfunction

    function automatic logic [data_w-1:0] expected_tile(input logic layer,
                                                        input logic [pos_w-1:0] h,
                                                        input logic [pos_w-1:0] v);
        logic [data_w-1:0] pg;
        int lay, x, y, page, addr;
        lay  = int'(layer);
        pg   = sel_value(lay);
        x    = (int'(h) + int'(sel_value(4 + lay))) % (map_cols * tile_px);
        y    = (int'(v) + int'(sel_value(2 + lay))) % (map_rows * tile_px);
        page = layer ? int'(pg[10:8]) : int'(pg[2:0]);
        if (page == int'(page_none)) begin
            return '0;
        end
        addr = page * page_words + (y / tile_px) * map_cols + x / tile_px;
        return ram_model[addr];
    endfunction

    // Called on a falling edge, returns on a falling edge after one idle cycle.
    task automatic cpu_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             input logic [be_w-1:0] be);
        logic [data_w-1:0] mask;
        mask      = {{8{be[1]}}, {8{be[0]}}};
        cpu_valid = 1'b1;
        cpu_addr  = addr;
        cpu_data  = data;
        cpu_be    = be;
        while (!cpu_ready) begin
            cpu_stalls++;
            @(negedge clk);
        end
        @(negedge clk);
        cpu_valid = 1'b0;
        if (addr < reg_base) begin
            ram_model[addr] = (ram_model[addr] & ~mask) | (data & mask);
        end else begin
            foreach (bank_model[r, b]) begin
                if (addr[off_w-1:0] == reg_offset(r, b)) begin
                    bank_model[r][b] = (bank_model[r][b] & ~mask) | (data & mask);
                end
            end
        end
        @(negedge clk);
    endtask

    task automatic check_dump();
        logic [data_w-1:0] val;
        logic [st_w-1:0]   exp_byte;
        for (int i = 0; i < st_entries + 2; i++) begin
            st_addr = st_w'(i);
            @(negedge clk);
            val      = sel_value(i / 2);
            exp_byte = (i >= st_entries) ? '0 : (i % 2 != 0) ? val[15:8] : val[7:0];
            assert (st_dout == exp_byte)
            else value_error($sformatf("status byte %0d is %h, expected %h", i, st_dout, exp_byte));
        end
        val = sel_value(4);
        assert (rowscr1_en == val[15]) else value_error("rowscr1_en does not follow hpos1");
        val = sel_value(5);
        assert (rowscr2_en == val[15]) else value_error("rowscr2_en does not follow hpos2");
    endtask

    // Sampling 1 ns after the falling edge sees what fires on the next rise.
    task automatic run_fetch(input int n, input int stall_pct, input bit sweep);
        int sent, got;
        bit req_fire, tile_fire;
        sent     = 0;
        got      = 0;
        req_fire = 1'b0;
        while (got < n) begin
            @(negedge clk);
            if (req_fire) begin
                req_valid = 1'b0;
            end
            if (!req_valid && sent < n) begin
                req_valid = 1'b1;
                req_layer = sweep ? 1'b0 : 1'($urandom);
                req_h     = sweep ? pos_w'((sent % map_cols) * tile_px) : pos_w'($urandom);
                req_v     = sweep ? pos_w'((sent / map_cols) * tile_px) : pos_w'($urandom);
            end
            tile_ready = $urandom_range(99) >= stall_pct;
            #1;
            req_fire  = req_valid && req_ready;
            tile_fire = tile_valid && tile_ready;
            if (req_fire) begin
                exp_q.push_back(expected_tile(req_layer, req_h, req_v));
                sent++;
            end
            if (tile_fire) begin
                assert (exp_q.size() > 0) else value_error("tile word with no request pending");
                assert (tile_data == exp_q[0])
                else value_error($sformatf("tile %0d is %h, expected %h", got, tile_data, exp_q[0]));
                void'(exp_q.pop_front());
                got++;
            end
        end
        @(negedge clk);
        req_valid  = 1'b0;
        tile_ready = 1'b1;
        assert (!tile_valid) else value_error("extra tile word after all requests were served");
    endtask

    initial begin
        logic [data_w-1:0] data;
        void'($urandom(32'h48d1082f));
        reset      = 1'b1;
        cpu_valid  = 1'b0;
        cpu_addr   = '0;
        cpu_data   = '0;
        cpu_be     = '0;
        req_valid  = 1'b0;
        req_layer  = 1'b0;
        req_h      = '0;
        req_v      = '0;
        tile_ready = 1'b1;
        altscr1_en = 1'b0;
        altscr2_en = 1'b0;
        st_addr    = '0;
        cycles     = 0;
        cpu_stalls = 0;
        foreach (bank_model[r, b]) begin
            bank_model[r][b] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // ******************************
        // Registers and status dump
        // ******************************
        check_dump();
        repeat (40) begin
            cpu_write(reg_base + addr_w'(reg_offset($urandom_range(5), $urandom_range(1))),
                      16'($urandom), 2'($urandom));
            check_dump();
        end
        // Unused offset in the window.
        cpu_write(reg_base + addr_w'(8'h10), 16'hffff, 2'b11);
        check_dump();
        for (int i = 0; i < 4; i++) begin
            altscr1_en = i[0];
            altscr2_en = i[1];
            @(negedge clk);
            check_dump();
        end

        // ******************************
        // Tile RAM and fetch
        // ******************************
        for (int a = 0; a < ram_words; a++) begin
            cpu_write(addr_w'(a), 16'($urandom), 2'b11);
        end
        repeat (100) begin
            cpu_write(addr_w'($urandom_range(ram_words - 1)), 16'($urandom), 2'($urandom));
        end
        for (int round = 0; round < 6; round++) begin
            foreach (bank_model[r, b]) begin
                data = 16'($urandom);
                // First round puts both layers on the blank page.
                if (round == 0 && r < 2) begin
                    data |= 16'h0707;
                end
                cpu_write(reg_base + addr_w'(reg_offset(r, b)), data, 2'b11);
            end
            altscr1_en = 1'($urandom);
            altscr2_en = 1'($urandom);
            @(negedge clk);
            check_dump();
            run_fetch(48, (round % 2 != 0) ? 40 : 0, 1'b0);
        end

        // CPU writes into page 4 while layers read pages 1 and 2.
        altscr1_en = 1'b0;
        altscr2_en = 1'b0;
        cpu_write(reg_base + addr_w'(off_pages1_std), 16'h0001, 2'b11);
        cpu_write(reg_base + addr_w'(off_pages2_std), 16'h0200, 2'b11);
        cpu_stalls = 0;
        fork
            run_fetch(200, 30, 1'b0);
            repeat (40) begin
                cpu_write(addr_w'(4 * page_words + $urandom_range(page_words - 1)),
                          16'($urandom), 2'($urandom));
            end
        join
        assert (cpu_stalls > 0) else value_error("no CPU write was held off by fetch traffic");
        cpu_write(reg_base + addr_w'(off_pages1_std), 16'h0004, 2'b11);
        run_fetch(page_words, 20, 1'b1);

        if (!dut_i.props_i.assert_failed) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("A bound protocol assertion failed");
            $display("=== FAIL ===");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
tilevid_pkg.sv
char_window.sv
scroll_mmr.sv
tile_fetch.sv
tilevid_top.sv
tilevid_properties.sv
tb_tilevid.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP       ?= tb_tilevid
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
